/* source/asrm_pkg.sv */
//////////////////////////////////////////////////
// asrm_pkg
// word size, RAM depth and the encodings shared by
// the stack CPU memory side
//////////////////////////////////////////////////

package asrm_pkg;

    localparam int word_size = 16;     // data and address width
    localparam int ram_depth = 256;    // words of program and data
    localparam int ram_addr_bits = $clog2(ram_depth);

    // full 8-bit opcodes, operand class nibble is zero
    typedef enum logic [7:0] {
        inst_nop  = 8'h00,
        inst_push = 8'h01,
        inst_pop  = 8'h02,
        inst_call = 8'h03,
        inst_ret  = 8'h04,
        inst_swap = 8'h05,    // exchange working and other register
        inst_halt = 8'h0F
    } inst_e;

    // operand classes in the upper nibble, immediate in the low nibble
    typedef enum logic [3:0] {
        opp_none     = 4'h0,
        opp_str      = 4'h1,  // mem[other] = work
        opp_load     = 4'h2,  // work = mem[other]
        opp_ldi      = 4'h3,  // work = imm
        opp_addi     = 4'h4,  // work = work + imm
        opp_stw      = 4'h5,  // status[2:1] = imm[1:0]
        opp_call_abs = 4'h6   // reserved, runs as nop
    } opp_e;

    // load width modes held in status bits 2:1
    typedef enum logic [1:0] {
        width_full = 2'b00,
        width_res1 = 2'b01,   // wider modes collapse to full at 16 bits
        width_res2 = 2'b10,
        width_byte = 2'b11    // low byte, zero extended
    } width_e;

    // sequencer phases
    typedef enum logic [1:0] {
        phase_fetch,
        phase_mem,
        phase_halt
    } phase_e;

endpackage

/* source/asrm_mem_if.sv */
//////////////////////////////////////////////////
// asrm_mem_if
// RAM access bus between the sequencer and the RAM
//////////////////////////////////////////////////

interface asrm_mem_if
    import asrm_pkg::*;
(
    input logic clk
);

    logic [word_size-1:0] addr;
    logic [word_size-1:0] wdata;
    logic [word_size-1:0] rdata;    // registered, one cycle after addr
    logic                 write_en;

    // sequencer side
    modport mem_master (
        output addr,
        output wdata,
        output write_en,
        input  rdata
    );

    // RAM side
    modport mem_slave (
        input  clk,
        input  addr,
        input  wdata,
        input  write_en,
        output rdata
    );

endinterface

/* source/asrm_addr.sv */
//////////////////////////////////////////////////
// asrm_addr
// sequences every RAM access: instruction fetch,
// then an optional stack or load/store phase, and
// hands the narrowed load value back to the registers
//////////////////////////////////////////////////

module asrm_addr
    import asrm_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic [word_size-1:0] work_reg,
    input  logic [word_size-1:0] other_reg,
    input  logic [word_size-1:0] pc,
    input  logic [word_size-1:0] sp,
    input  logic [word_size-1:0] status,
    output inst_e                instruction,
    output logic [word_size-1:0] result,
    output logic                 retire,
    output logic                 halted,
    asrm_mem_if.mem_master       mem
);

    phase_e               phase;
    logic [1:0]           count;       // 2, 1, 0 within every phase
    logic [word_size-1:0] data_buff;   // narrowed load value
    logic [word_size-1:0] narrowed;
    logic [word_size-1:0] imm;
    opp_e                 operand;
    width_e               width_mode;
    logic                 fetching;
    logic                 using_ram;
    logic                 writes_ram;
    logic                 returning_value;
    logic [word_size-1:0] addr_pop;
    logic [word_size-1:0] addr_push;
    logic [word_size-1:0] addr_reg;
    logic [word_size-1:0] data_wr;
    logic [word_size-1:0] data_pc;

    assign operand    = opp_e'(instruction[7:4]);
    assign imm        = {{(word_size-4){1'b0}}, instruction[3:0]};
    assign width_mode = width_e'(status[2:1]);
    assign fetching   = (phase == phase_fetch);

    // instruction decode
    assign using_ram = instruction == inst_push || instruction == inst_pop
                    || instruction == inst_call || instruction == inst_ret
                    || operand == opp_str || operand == opp_load;
    assign writes_ram = instruction == inst_push || instruction == inst_call
                     || operand == opp_str;
    assign returning_value = instruction == inst_pop || instruction == inst_ret
                          || operand == opp_load;

    // one-hot address terms, only one is nonzero per opcode
    // registers already moved sp for pop and ret? no, they do it at retire
    assign addr_pop  = (instruction == inst_pop || instruction == inst_ret)
                       ? sp - word_size'(1) : '0;
    assign addr_push = (instruction == inst_push || instruction == inst_call) ? sp : '0;
    assign addr_reg  = (operand == opp_str || operand == opp_load) ? other_reg : '0;

    assign mem.addr = fetching ? pc : (addr_reg | addr_pop | addr_push);

    // write data, call pushes the return address
    assign data_wr   = (instruction == inst_push || operand == opp_str) ? work_reg : '0;
    assign data_pc   = (instruction == inst_call) ? pc + word_size'(1) : '0;
    assign mem.wdata = data_wr | data_pc;

    assign mem.write_en = (phase == phase_mem) && writes_ram;

    // narrow the read word by the status width mode
    always_comb
    begin
        case (width_mode)
            width_full: narrowed = mem.rdata;
            width_res1: narrowed = mem.rdata;   // 32-bit mode, full word here
            width_res2: narrowed = mem.rdata;
            width_byte: narrowed = {{(word_size-8){1'b0}}, mem.rdata[7:0]};
            default:    narrowed = mem.rdata;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (run && phase == phase_mem && count == 2'd1 && returning_value)
            data_buff <= narrowed;   // rdata holds the phase address here
    end

    // value for the working register at retire
    always_comb
    begin
        if (returning_value)
            result = data_buff;
        else if (operand == opp_ldi)
            result = imm;
        else if (operand == opp_addi)
            result = work_reg + imm;
        else
            result = work_reg;    // unchanged
    end

    assign retire = run && count == 2'd0
                 && ((fetching && !using_ram) || phase == phase_mem);
    assign halted = (phase == phase_halt);

    // phase counter and instruction latch
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            phase       <= phase_fetch;
            count       <= 2'd2;
            instruction <= inst_nop;
        end
        else if (run)
        begin
            case (phase)
                phase_fetch:
                begin
                    if (count == 2'd1)
                        instruction <= inst_e'(mem.rdata[7:0]);
                    if (count == 2'd0)
                    begin
                        count <= 2'd2;
                        if (instruction == inst_halt)
                            phase <= phase_halt;
                        else if (using_ram)
                            phase <= phase_mem;
                    end
                    else
                        count <= count - 2'd1;
                end
                phase_mem:
                begin
                    if (count == 2'd0)
                    begin
                        count <= 2'd2;
                        phase <= phase_fetch;
                    end
                    else
                        count <= count - 2'd1;
                end
                default: phase <= phase_halt;    // stays until reset
            endcase
        end
    end

endmodule

/* source/asrm_regs.sv */
//////////////////////////////////////////////////
// asrm_regs
// architectural registers of the stack CPU, updated
// once per retired instruction
//////////////////////////////////////////////////

module asrm_regs
    import asrm_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  inst_e                instruction,
    input  logic [word_size-1:0] result,
    input  logic                 retire,
    input  logic                 halted,
    output logic [word_size-1:0] work_reg,
    output logic [word_size-1:0] other_reg,
    output logic [word_size-1:0] pc,
    output logic [word_size-1:0] sp,
    output logic [word_size-1:0] status,
    output logic [15:0]          retire_count
);

    opp_e                 operand;
    logic [word_size-1:0] next_pc;
    logic [word_size-1:0] next_sp;

    assign operand = opp_e'(instruction[7:4]);

    // program counter target
    always_comb
    begin
        case (instruction)
            inst_call: next_pc = other_reg;
            inst_ret:  next_pc = result;       // popped return address
            inst_halt: next_pc = pc;           // pc parks on the halt
            default:   next_pc = pc + word_size'(1);
        endcase
    end

    // stack grows upward from address 0
    always_comb
    begin
        case (instruction)
            inst_push,
            inst_call: next_sp = sp + word_size'(1);
            inst_pop,
            inst_ret:  next_sp = sp - word_size'(1);
            default:   next_sp = sp;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            work_reg     <= '0;
            other_reg    <= '0;
            pc           <= '0;
            sp           <= '0;
            status       <= '0;
            retire_count <= '0;
        end
        else if (retire && !halted)
        begin
            retire_count <= retire_count + 16'd1;
            pc           <= next_pc;
            sp           <= next_sp;

            case (instruction)
                inst_swap:
                begin
                    work_reg  <= other_reg;
                    other_reg <= work_reg;
                end
                inst_ret: ;    // result carries the return address
                default:  work_reg <= result;
            endcase

            if (operand == opp_stw)
                status[2:1] <= instruction[1:0];   // load width mode
        end
    end

endmodule

/* source/asrm_ram.sv */
//////////////////////////////////////////////////
// asrm_ram
// single-port synchronous RAM, host port takes over
// while the core is stopped
//////////////////////////////////////////////////

module asrm_ram
    import asrm_pkg::*;
(
    input  logic                 clk,
    input  logic                 run,
    input  logic                 host_we,
    input  logic [word_size-1:0] host_addr,
    input  logic [word_size-1:0] host_wdata,
    output logic [word_size-1:0] host_rdata,
    asrm_mem_if.mem_slave        mem
);

    logic [word_size-1:0]     storage [ram_depth];
    logic [word_size-1:0]     read_q;
    logic [ram_addr_bits-1:0] port_addr;
    logic [word_size-1:0]     port_wdata;
    logic                     port_we;

    // port owner, core while running
    assign port_addr  = run ? mem.addr[ram_addr_bits-1:0] : host_addr[ram_addr_bits-1:0];
    assign port_wdata = run ? mem.wdata : host_wdata;
    assign port_we    = run ? mem.write_en : host_we;

    always_ff @(posedge clk)
    begin
        if (port_we)
            storage[port_addr] <= port_wdata;
        read_q <= storage[port_addr];   // read before write
    end

    // both sides see the same registered read
    assign mem.rdata  = read_q;
    assign host_rdata = read_q;

endmodule

/* source/asrm_top.sv */
//////////////////////////////////////////////////
// asrm_top
// memory side of the stack CPU: register block,
// RAM sequencer and program/data RAM
//////////////////////////////////////////////////

module asrm_top
    import asrm_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 host_we,
    input  logic [word_size-1:0] host_addr,
    input  logic [word_size-1:0] host_wdata,
    output logic [word_size-1:0] host_rdata,
    output logic [word_size-1:0] work_reg,
    output logic [word_size-1:0] pc,
    output logic                 halted,
    output logic [15:0]          retire_count
);

    logic [word_size-1:0] other_reg;
    logic [word_size-1:0] sp;
    logic [word_size-1:0] status;
    logic [word_size-1:0] result;
    logic                 retire;
    inst_e                instruction;

    asrm_mem_if mem_bus (.clk(clk));

    asrm_addr addr_i (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .work_reg    (work_reg),
        .other_reg   (other_reg),
        .pc          (pc),
        .sp          (sp),
        .status      (status),
        .instruction (instruction),
        .result      (result),
        .retire      (retire),
        .halted      (halted),
        .mem         (mem_bus.mem_master)
    );

    asrm_regs regs_i (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .result       (result),
        .retire       (retire),
        .halted       (halted),
        .work_reg     (work_reg),
        .other_reg    (other_reg),
        .pc           (pc),
        .sp           (sp),
        .status       (status),
        .retire_count (retire_count)
    );

    asrm_ram ram_i (
        .clk        (clk),
        .run        (run),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .mem        (mem_bus.mem_slave)
    );

endmodule

/* tests/asrm_tb.sv */
//////////////////////////////////////////////////
// asrm_tb
// loads small programs through the host port, runs
// them on the core and checks registers and RAM words
//////////////////////////////////////////////////

module asrm_tb
    import asrm_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ram_window       = 96;     // words loaded and dumped per test
    localparam int prog_base        = 16;     // boot code calls here
    localparam int max_instructions = 300;
    localparam int run_budget       = 6 * max_instructions + 200;   // 6 cycles worst case

    logic                 clk;
    logic                 reset;
    logic                 run;
    logic                 host_we;
    logic [word_size-1:0] host_addr;
    logic [word_size-1:0] host_wdata;
    logic [word_size-1:0] host_rdata;
    logic [word_size-1:0] work_reg;
    logic [word_size-1:0] pc;
    logic                 halted;
    logic [15:0]          retire_count;

    logic [word_size-1:0] image [ram_window];    // RAM contents before the run
    logic [word_size-1:0] dumped [ram_window];   // RAM contents after the run
    logic [31:0]          rng_state;
    string                test_name;
    int                   prog_ptr;
    int                   boot_length;
    int                   run_cycles;
    int                   test_errors;
    int                   total_errors;
    int                   tests_run;
    int                   tests_failed;

    asrm_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_rdata   (host_rdata),
        .work_reg     (work_reg),
        .pc           (pc),
        .halted       (halted),
        .retire_count (retire_count)
    );

    always #20 clk = ~clk;

    // ends a run whose program never reaches halt
    always @(posedge clk)
    begin
        if (!run || halted)
            run_cycles = 0;
        else if (run_cycles < run_budget)
            run_cycles++;
        else
        begin
            $display("test %s: core did not halt within %0d cycles", test_name, run_budget);
            $display("Finished with errors");
            $finish;
        end
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string what, input logic [word_size-1:0] expected,
                               input logic [word_size-1:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic emit_inst(input inst_e op);
        image[prog_ptr] = {8'h00, op};
        prog_ptr++;
    endtask

    task automatic emit_imm(input opp_e cls, input logic [3:0] value);
        image[prog_ptr] = {8'h00, cls, value};
        prog_ptr++;
    endtask

    // ldi then addi steps of at most 15
    task automatic build_value(input int value);
        int left;
        int step;
        left = value;
        step = (left > 15) ? 15 : left;
        emit_imm(opp_ldi, 4'(step));
        left = left - step;
        while (left > 0)
        begin
            step = (left > 15) ? 15 : left;
            emit_imm(opp_addi, 4'(step));
            left = left - step;
        end
    endtask

    task automatic begin_test(input string name);
        int a;
        test_name   = name;
        test_errors = 0;
        for (a = 0; a < ram_window; a++)
            image[a] = {8'(a) ^ 8'ha5, 8'(a)};
        // boot code runs from the reset pc and calls up past the stack base at 0
        prog_ptr = 0;
        build_value(prog_base);
        emit_inst(inst_swap);
        emit_inst(inst_call);
        boot_length = prog_ptr;
        prog_ptr    = prog_base;
        emit_inst(inst_pop);    // drops the boot return address so sp is 0 again
    endtask

    // reset, load the image with the core stopped, then run until halt
    task automatic start_program();
        int a;
        @(negedge clk);
        run   = 1'b0;
        reset = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b1;
        for (a = 0; a < ram_window; a++)
        begin
            host_we    = 1'b1;
            host_addr  = 16'(a);
            host_wdata = image[a];
            @(negedge clk);
        end
        host_we = 1'b0;
        run     = 1'b1;
        while (!halted)
            @(negedge clk);
    endtask

    task automatic stop_program();
        int a;
        run       = 1'b0;    // host owns the RAM again
        host_addr = '0;
        for (a = 0; a < ram_window; a++)
        begin
            @(negedge clk);
            dumped[a] = host_rdata;    // registered read of the previous address
            host_addr = 16'(a + 1);
        end
    endtask

    task automatic end_test();
        tests_run++;
        total_errors = total_errors + test_errors;
        if (test_errors == 0)
            $display("test %s passed", test_name);
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_immediate_add();
        logic [3:0]           nib;
        logic [word_size-1:0] sum;
        begin_test("immediate_add");
        nib = 4'(next_random());
        sum = {12'h000, nib};
        emit_imm(opp_ldi, nib);
        repeat (6)
        begin
            nib = 4'(next_random());
            sum = sum + {12'h000, nib};
            emit_imm(opp_addi, nib);
        end
        emit_inst(inst_halt);
        start_program();
        stop_program();
        check_value("work_reg", sum, work_reg);
        end_test();
    endtask

    task automatic test_store_load();
        int addr;
        int value;
        begin_test("store_load");
        addr  = 60 + int'(4'(next_random()));    // data area above the code
        value = 1 + int'(next_random() % 32'd90);
        build_value(addr);
        emit_inst(inst_swap);
        build_value(value);
        emit_imm(opp_str, 4'h0);
        emit_imm(opp_ldi, 4'h0);    // clear before reading back
        emit_imm(opp_load, 4'h0);
        emit_inst(inst_halt);
        start_program();
        stop_program();
        check_value("work_reg", 16'(value), work_reg);
        check_value("stored word", 16'(value), dumped[addr]);
        end_test();
    endtask

    task automatic test_stack_order();
        logic [word_size-1:0] pushed [3];
        int                   i;
        begin_test("stack_order");
        build_value(64);
        emit_inst(inst_swap);    // other_reg points at the pop results
        for (i = 0; i < 3; i++)
        begin
            pushed[i] = 16'(1 + int'(next_random() % 32'd30));
            build_value(int'(pushed[i]));
            emit_inst(inst_push);
        end
        for (i = 0; i < 3; i++)
        begin
            emit_inst(inst_pop);
            emit_imm(opp_str, 4'h0);
            emit_inst(inst_swap);
            emit_imm(opp_addi, 4'h1);    // next result slot
            emit_inst(inst_swap);
        end
        emit_inst(inst_halt);
        start_program();
        stop_program();
        for (i = 0; i < 3; i++)
        begin
            check_value($sformatf("stack word %0d", i), pushed[i], dumped[i]);
            check_value($sformatf("pop %0d", i), pushed[2 - i], dumped[64 + i]);
        end
        end_test();
    endtask

    task automatic test_call_return();
        logic [3:0] a_nib;
        logic [3:0] b_nib;
        int         call_addr;
        int         halt_addr;
        begin_test("call_return");
        build_value(64);    // subroutine entry
        emit_inst(inst_swap);
        call_addr = prog_ptr;
        emit_inst(inst_call);
        emit_imm(opp_addi, 4'h1);
        halt_addr = prog_ptr;
        emit_inst(inst_halt);
        a_nib    = 4'(next_random());
        b_nib    = 4'(next_random());
        prog_ptr = 64;
        emit_imm(opp_ldi, a_nib);
        emit_imm(opp_addi, b_nib);
        emit_inst(inst_ret);
        start_program();
        stop_program();
        check_value("work_reg", {12'h000, a_nib} + {12'h000, b_nib} + 16'd1, work_reg);
        check_value("pc", 16'(halt_addr), pc);
        check_value("return address", 16'(call_addr + 1), dumped[0]);
        end_test();
    endtask

    task automatic test_width_mode();
        logic [word_size-1:0] data;
        begin_test("width_mode");
        data      = 16'(next_random());
        data[15]  = 1'b1;    // high byte never zero
        image[80] = data;
        build_value(80);
        emit_inst(inst_swap);
        emit_imm(opp_stw, 4'h3);    // byte loads
        emit_imm(opp_load, 4'h0);
        emit_inst(inst_push);
        emit_imm(opp_stw, 4'h0);    // full loads again
        emit_imm(opp_load, 4'h0);
        emit_inst(inst_halt);
        start_program();
        stop_program();
        check_value("byte load", {8'h00, data[7:0]}, dumped[0]);
        check_value("work_reg", data, work_reg);
        end_test();
    endtask

    task automatic test_retire_halt();
        logic [3:0] nib;
        int         nops;
        int         halt_addr;
        int         expected_count;
        begin_test("retire_halt");
        nops = 1 + int'(next_random() % 32'd8);
        repeat (nops) emit_inst(inst_nop);
        nib = 4'(next_random());
        emit_imm(opp_ldi, nib);
        halt_addr = prog_ptr;
        emit_inst(inst_halt);
        expected_count = boot_length + (prog_ptr - prog_base);    // straight line code
        start_program();
        check_value("retire_count", 16'(expected_count), retire_count);
        repeat (20)
        begin
            @(negedge clk);
            check_value("work_reg after halt", {12'h000, nib}, work_reg);
            check_value("pc after halt", 16'(halt_addr), pc);
        end
        stop_program();
        end_test();
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b0;
        run          = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        rng_state    = 32'd92;
        run_cycles   = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;

        test_immediate_add();
        test_store_load();
        test_stack_order();
        test_call_return();
        test_width_mode();
        test_retire_halt();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
        if (total_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* asrm_top.f */
source/asrm_pkg.sv
source/asrm_mem_if.sv
source/asrm_addr.sv
source/asrm_regs.sv
source/asrm_ram.sv
source/asrm_top.sv
tests/asrm_tb.sv

/* Makefile */
# Verilator build and run for the asrm testbench

VERILATOR ?= verilator
TOP       ?= asrm_tb
FILELIST  ?= asrm_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
